/* loader_settings.svh */
`ifndef LOADER_SETTINGS_SVH
`define LOADER_SETTINGS_SVH

// Host bus widths
`define LDR_MMIO_ADDR_W 16
`define LDR_MMIO_DATA_W 64
`define LDR_HOST_ADDR_W 64
`define LDR_SIZE_W 43

// Beat geometry
`define LDR_BEAT_W 512
`define LDR_WORD_W 32
`define LDR_WORDS_PER_BEAT 16

// MMIO address fields
`define LDR_ARM_BIT 15
`define LDR_SIZE_MSB 14
`define LDR_SIZE_LSB 2
`define LDR_STATUS_BIT 1

`endif

/* host_if_pkg.sv */
`include "loader_settings.svh"

package host_if_pkg;

    // MMIO side
    typedef logic [`LDR_MMIO_ADDR_W-1:0] mmio_addr_t;
    typedef logic [`LDR_MMIO_DATA_W-1:0] mmio_data_t;

    // DMA read descriptor
    typedef logic [`LDR_HOST_ADDR_W-1:0] host_addr_t;
    // Counted in beats
    typedef logic [`LDR_SIZE_W-1:0] dma_size_t;

    // DMA payload
    typedef logic [`LDR_BEAT_W-1:0] beat_t;
    typedef logic [`LDR_WORD_W-1:0] word_t;

endpackage

/* loader_pkg.sv */
package loader_pkg;

    // Which descriptor the next MMIO write fills
    typedef enum logic [1:0] {
        CFG_CP,
        CFG_RT,
        CFG_CONST,
        CFG_START
    } cfg_state_e;

    // Segment currently walked by the read sequencer
    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_CP,
        SEQ_RT,
        SEQ_CONST
    } seq_state_e;

    typedef enum logic [1:0] {
        SEG_CP,
        SEG_RT,
        SEG_CONST
    } segment_e;

endpackage

/* mmio_config.sv */
`timescale 1ns/1ns
`include "loader_settings.svh"

module mmio_config (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    mmio_wr_en,
    input  host_if_pkg::mmio_addr_t mmio_wr_addr,
    input  host_if_pkg::mmio_data_t mmio_wr_data,
    output host_if_pkg::host_addr_t cp_addr,
    output host_if_pkg::host_addr_t rt_addr,
    output host_if_pkg::host_addr_t const_addr,
    output host_if_pkg::dma_size_t  rt_size,
    output host_if_pkg::dma_size_t  const_size,
    output logic                    cp_armed,
    output logic                    rt_armed,
    output logic                    const_armed,
    output logic                    load_start
);

    loader_pkg::cfg_state_e state;
    loader_pkg::cfg_state_e state_nxt;
    logic                    wr_ok;
    logic                    arm;
    logic                    cap_cp;
    logic                    cap_rt;
    logic                    cap_const;
    logic                    start_req;
    host_if_pkg::dma_size_t  size_field;
    host_if_pkg::host_addr_t base;

    // Status accesses never advance the descriptor sequence
    assign wr_ok = mmio_wr_en && !mmio_wr_addr[`LDR_STATUS_BIT];
    assign arm = mmio_wr_addr[`LDR_ARM_BIT];
    assign size_field = host_if_pkg::dma_size_t'(mmio_wr_addr[`LDR_SIZE_MSB:`LDR_SIZE_LSB]);
    assign base = host_if_pkg::host_addr_t'(mmio_wr_data);

    always_comb begin
        state_nxt = state;
        cap_cp = 1'b0;
        cap_rt = 1'b0;
        cap_const = 1'b0;
        start_req = 1'b0;
        case (state)
            loader_pkg::CFG_CP: begin
                // An unarmed CP write is dropped
                if (wr_ok && arm) begin
                    cap_cp = 1'b1;
                    state_nxt = loader_pkg::CFG_RT;
                end
            end
            loader_pkg::CFG_RT: begin
                if (wr_ok) begin
                    cap_rt = 1'b1;
                    state_nxt = loader_pkg::CFG_CONST;
                end
            end
            loader_pkg::CFG_CONST: begin
                if (wr_ok) begin
                    cap_const = 1'b1;
                    state_nxt = loader_pkg::CFG_START;
                end
            end
            default: begin
                if (wr_ok) begin
                    start_req = 1'b1;
                    state_nxt = loader_pkg::CFG_CP;
                end
            end
        endcase
    end

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            state <= loader_pkg::CFG_CP;
            load_start <= 1'b0;
        end else begin
            state <= state_nxt;
            load_start <= start_req;
        end
    end

    // Segment descriptors
    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            cp_addr <= '0;
            cp_armed <= 1'b0;
            rt_addr <= '0;
            rt_size <= '0;
            rt_armed <= 1'b0;
            const_addr <= '0;
            const_size <= '0;
            const_armed <= 1'b0;
        end else if (cap_cp) begin
            cp_addr <= base;
            cp_armed <= arm;
        end else if (cap_rt) begin
            rt_addr <= base;
            rt_size <= size_field;
            rt_armed <= arm;
        end else if (cap_const) begin
            const_addr <= base;
            const_size <= size_field;
            const_armed <= arm;
        end
    end

endmodule

/* read_sequencer.sv */
`timescale 1ns/1ns

module read_sequencer (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    load_start,
    input  host_if_pkg::host_addr_t cp_addr,
    input  host_if_pkg::host_addr_t rt_addr,
    input  host_if_pkg::host_addr_t const_addr,
    input  host_if_pkg::dma_size_t  rt_size,
    input  host_if_pkg::dma_size_t  const_size,
    input  logic                    cp_armed,
    input  logic                    rt_armed,
    input  logic                    const_armed,
    input  logic                    seg_end,
    output logic                    seg_start,
    output host_if_pkg::host_addr_t seg_addr,
    output host_if_pkg::dma_size_t  seg_size,
    output loader_pkg::segment_e    active_seg,
    output logic                    cp_strt
);

    loader_pkg::seq_state_e state;
    loader_pkg::seq_state_e state_nxt;
    logic                   launched;
    logic                   launched_nxt;
    logic                   seg_armed;
    logic                   done_nxt;

    // Descriptor of the segment being walked
    always_comb begin
        case (state)
            loader_pkg::SEQ_RT: begin
                active_seg = loader_pkg::SEG_RT;
                seg_addr = rt_addr;
                seg_size = rt_size;
                seg_armed = rt_armed;
            end
            loader_pkg::SEQ_CONST: begin
                active_seg = loader_pkg::SEG_CONST;
                seg_addr = const_addr;
                seg_size = const_size;
                seg_armed = const_armed;
            end
            default: begin
                active_seg = loader_pkg::SEG_CP;
                seg_addr = cp_addr;
                // CP is always one beat
                seg_size = host_if_pkg::dma_size_t'(1);
                seg_armed = cp_armed;
            end
        endcase
    end

    always_comb begin
        state_nxt = state;
        launched_nxt = launched;
        seg_start = 1'b0;
        done_nxt = 1'b0;
        if (state == loader_pkg::SEQ_IDLE) begin
            if (load_start) begin
                state_nxt = loader_pkg::SEQ_CP;
            end
        end else if (!seg_armed || (launched && seg_end)) begin
            launched_nxt = 1'b0;
            case (state)
                loader_pkg::SEQ_CP: state_nxt = loader_pkg::SEQ_RT;
                loader_pkg::SEQ_RT: state_nxt = loader_pkg::SEQ_CONST;
                default: begin
                    state_nxt = loader_pkg::SEQ_IDLE;
                    done_nxt = 1'b1;
                end
            endcase
        end else if (!launched) begin
            seg_start = 1'b1;
            launched_nxt = 1'b1;
        end
    end

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            state <= loader_pkg::SEQ_IDLE;
            launched <= 1'b0;
            cp_strt <= 1'b0;
        end else begin
            state <= state_nxt;
            launched <= launched_nxt;
            cp_strt <= done_nxt;
        end
    end

endmodule

/* beat_unpacker.sv */
`timescale 1ns/1ns
`include "loader_settings.svh"

module beat_unpacker (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               beat_load,
    input  host_if_pkg::beat_t beat_in,
    output logic               word_valid,
    output host_if_pkg::word_t data_32,
    output logic               beat_drained
);

    localparam int CNT_W = $clog2(`LDR_WORDS_PER_BEAT);

    host_if_pkg::word_t words [`LDR_WORDS_PER_BEAT];
    logic [CNT_W-1:0]   word_cnt;

    assign data_32 = words[0];
    assign beat_drained = word_valid && (word_cnt == CNT_W'(`LDR_WORDS_PER_BEAT - 1));

    // Word 0 sits at the bottom of the beat
    always_ff @(posedge clk) begin
        if (beat_load) begin
            for (int i = 0; i < `LDR_WORDS_PER_BEAT; i++) begin
                words[i] <= beat_in[i*`LDR_WORD_W +: `LDR_WORD_W];
            end
        end else if (word_valid) begin
            for (int i = 0; i < `LDR_WORDS_PER_BEAT - 1; i++) begin
                words[i] <= words[i+1];
            end
        end
    end

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            word_valid <= 1'b0;
            word_cnt <= '0;
        end else if (beat_load) begin
            word_valid <= 1'b1;
            word_cnt <= '0;
        end else if (word_valid) begin
            word_cnt <= word_cnt + 1'b1;
            if (beat_drained) begin
                word_valid <= 1'b0;
            end
        end
    end

endmodule

/* dma_read_engine.sv */
`timescale 1ns/1ns

module dma_read_engine (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    seg_start,
    input  host_if_pkg::host_addr_t seg_addr,
    input  host_if_pkg::dma_size_t  seg_size,
    input  logic                    dma_empty,
    input  host_if_pkg::beat_t      dma_rd_data,
    output logic                    dma_rd_go,
    output logic                    dma_rd_en,
    output host_if_pkg::host_addr_t dma_rd_addr,
    output host_if_pkg::dma_size_t  dma_rd_size,
    output logic                    word_valid,
    output host_if_pkg::word_t      data_32,
    output logic                    seg_end
);

    host_if_pkg::dma_size_t beats_left;
    logic                   busy;
    logic                   holding;
    logic                   beat_drained;
    logic                   no_beats_left;
    logic                   can_pop;

    assign no_beats_left = (beats_left == '0);

    // Unpacker free, or on its last word so the next beat follows back to back
    assign can_pop = !holding || beat_drained;

    assign dma_rd_en = busy && !dma_rd_go && !no_beats_left && can_pop && !dma_empty;

    // Last beat drained; a zero-size segment ends right after its go
    assign seg_end = busy && !dma_rd_go && no_beats_left && can_pop;

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            dma_rd_go <= 1'b0;
            busy <= 1'b0;
            holding <= 1'b0;
            beats_left <= '0;
        end else begin
            dma_rd_go <= seg_start;
            if (seg_start) begin
                busy <= 1'b1;
            end else if (seg_end) begin
                busy <= 1'b0;
            end
            if (seg_start) begin
                beats_left <= seg_size;
            end else if (dma_rd_en) begin
                beats_left <= beats_left - 1'b1;
            end
            if (dma_rd_en) begin
                holding <= 1'b1;
            end else if (beat_drained) begin
                holding <= 1'b0;
            end
        end
    end

    // Read descriptor held for the DMA
    always_ff @(posedge clk) begin
        if (seg_start) begin
            dma_rd_addr <= seg_addr;
            dma_rd_size <= seg_size;
        end
    end

    beat_unpacker beat_unpacker_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .beat_load    (dma_rd_en),
        .beat_in      (dma_rd_data),
        .word_valid   (word_valid),
        .data_32      (data_32),
        .beat_drained (beat_drained)
    );

endmodule

/* param_loader.sv */
`timescale 1ns/1ns

module param_loader (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    mmio_wr_en,
    input  host_if_pkg::mmio_addr_t mmio_wr_addr,
    input  host_if_pkg::mmio_data_t mmio_wr_data,
    input  logic                    dma_empty,
    input  host_if_pkg::beat_t      dma_rd_data,
    output logic                    dma_rd_go,
    output logic                    dma_rd_en,
    output host_if_pkg::host_addr_t dma_rd_addr,
    output host_if_pkg::dma_size_t  dma_rd_size,
    output host_if_pkg::word_t      data_32,
    output logic                    we_cp,
    output logic                    we_rt,
    output logic                    we_const,
    output logic                    cp_strt
);

    host_if_pkg::host_addr_t cp_addr;
    host_if_pkg::host_addr_t rt_addr;
    host_if_pkg::host_addr_t const_addr;
    host_if_pkg::dma_size_t  rt_size;
    host_if_pkg::dma_size_t  const_size;
    logic                    cp_armed;
    logic                    rt_armed;
    logic                    const_armed;
    logic                    load_start;
    logic                    seg_start;
    host_if_pkg::host_addr_t seg_addr;
    host_if_pkg::dma_size_t  seg_size;
    logic                    seg_end;
    loader_pkg::segment_e    active_seg;
    logic                    word_valid;

    mmio_config mmio_config_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .mmio_wr_en   (mmio_wr_en),
        .mmio_wr_addr (mmio_wr_addr),
        .mmio_wr_data (mmio_wr_data),
        .cp_addr      (cp_addr),
        .rt_addr      (rt_addr),
        .const_addr   (const_addr),
        .rt_size      (rt_size),
        .const_size   (const_size),
        .cp_armed     (cp_armed),
        .rt_armed     (rt_armed),
        .const_armed  (const_armed),
        .load_start   (load_start)
    );

    read_sequencer read_sequencer_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .load_start  (load_start),
        .cp_addr     (cp_addr),
        .rt_addr     (rt_addr),
        .const_addr  (const_addr),
        .rt_size     (rt_size),
        .const_size  (const_size),
        .cp_armed    (cp_armed),
        .rt_armed    (rt_armed),
        .const_armed (const_armed),
        .seg_end     (seg_end),
        .seg_start   (seg_start),
        .seg_addr    (seg_addr),
        .seg_size    (seg_size),
        .active_seg  (active_seg),
        .cp_strt     (cp_strt)
    );

    dma_read_engine dma_read_engine_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .seg_start   (seg_start),
        .seg_addr    (seg_addr),
        .seg_size    (seg_size),
        .dma_empty   (dma_empty),
        .dma_rd_data (dma_rd_data),
        .dma_rd_go   (dma_rd_go),
        .dma_rd_en   (dma_rd_en),
        .dma_rd_addr (dma_rd_addr),
        .dma_rd_size (dma_rd_size),
        .word_valid  (word_valid),
        .data_32     (data_32),
        .seg_end     (seg_end)
    );

    // Local memory write enables
    assign we_cp = word_valid && (active_seg == loader_pkg::SEG_CP);
    assign we_rt = word_valid && (active_seg == loader_pkg::SEG_RT);
    assign we_const = word_valid && (active_seg == loader_pkg::SEG_CONST);

endmodule

/* param_loader_properties.sv */
`timescale 1ns/1ns

module param_loader_properties (
    input logic clk,
    input logic rst_n,
    input logic dma_empty,
    input logic dma_rd_go,
    input logic dma_rd_en,
    input logic we_cp,
    input logic we_rt,
    input logic we_const,
    input logic cp_strt
);

    // Pops only a presented beat
    a_pop_not_empty: assert property (
        @(posedge clk) disable iff (!rst_n)
        dma_rd_en |-> !dma_empty
    ) else $error("dma_rd_en high while dma_empty is high");

    a_go_pop_exclusive: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(dma_rd_go && dma_rd_en)
    ) else $error("dma_rd_go and dma_rd_en high in the same cycle");

    // One local memory written per word
    a_single_we: assert property (
        @(posedge clk) disable iff (!rst_n)
        $onehot0({we_cp, we_rt, we_const})
    ) else $error("more than one write enable high");

    a_strt_pulse: assert property (
        @(posedge clk) disable iff (!rst_n)
        cp_strt |=> !cp_strt
    ) else $error("cp_strt high for two cycles");

endmodule

/* tb_param_loader.sv */
`timescale 1ns/1ns
`include "loader_settings.svh"

module tb_param_loader;

    localparam int NUM_LOADS = 8;
    localparam int LOAD_TIMEOUT = 5000;

    logic                    clk;
    logic                    rst_n;
    logic                    mmio_wr_en;
    host_if_pkg::mmio_addr_t mmio_wr_addr;
    host_if_pkg::mmio_data_t mmio_wr_data;
    logic                    dma_empty;
    host_if_pkg::beat_t      dma_rd_data;
    logic                    dma_rd_go;
    logic                    dma_rd_en;
    host_if_pkg::host_addr_t dma_rd_addr;
    host_if_pkg::dma_size_t  dma_rd_size;
    host_if_pkg::word_t      data_32;
    logic                    we_cp;
    logic                    we_rt;
    logic                    we_const;
    logic                    cp_strt;

    integer                  seed;
    logic [31:0]             cfg_rnd;
    logic [31:0]             stall_rnd;
    string                   test_name;
    int                      loads_started;
    int                      strt_count;
    int                      we_count;
    loader_pkg::segment_e    seen_seg;

    // Per-load descriptors drawn before the clock runs
    host_if_pkg::host_addr_t cp_base [NUM_LOADS];
    host_if_pkg::host_addr_t rt_base [NUM_LOADS];
    host_if_pkg::host_addr_t const_base [NUM_LOADS];
    host_if_pkg::dma_size_t  cp_junk [NUM_LOADS];
    host_if_pkg::dma_size_t  rt_sz [NUM_LOADS];
    host_if_pkg::dma_size_t  const_sz [NUM_LOADS];
    logic                    rt_arm [NUM_LOADS];
    logic                    const_arm [NUM_LOADS];
    logic                    extra_status [NUM_LOADS];

    // Reference model output and host DMA queue
    host_if_pkg::host_addr_t exp_addr_q [$];
    host_if_pkg::dma_size_t  exp_size_q [$];
    loader_pkg::segment_e    exp_seg_q [$];
    host_if_pkg::word_t      exp_word_q [$];
    host_if_pkg::beat_t      beat_q [$];

    param_loader dut_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .mmio_wr_en   (mmio_wr_en),
        .mmio_wr_addr (mmio_wr_addr),
        .mmio_wr_data (mmio_wr_data),
        .dma_empty    (dma_empty),
        .dma_rd_data  (dma_rd_data),
        .dma_rd_go    (dma_rd_go),
        .dma_rd_en    (dma_rd_en),
        .dma_rd_addr  (dma_rd_addr),
        .dma_rd_size  (dma_rd_size),
        .data_32      (data_32),
        .we_cp        (we_cp),
        .we_rt        (we_rt),
        .we_const     (we_const),
        .cp_strt      (cp_strt)
    );

    bind param_loader param_loader_properties props_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .dma_empty (dma_empty),
        .dma_rd_go (dma_rd_go),
        .dma_rd_en (dma_rd_en),
        .we_cp     (we_cp),
        .we_rt     (we_rt),
        .we_const  (we_const),
        .cp_strt   (cp_strt)
    );

    always #4 clk = ~clk;

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_addr(input string what, input host_if_pkg::host_addr_t exp,
                              input host_if_pkg::host_addr_t act);
        if (act !== exp) begin
            fail_run($sformatf("mismatch %s %s: expected %h actual %h",
                               test_name, what, exp, act));
        end
    endtask

    task automatic check_size(input string what, input host_if_pkg::dma_size_t exp,
                              input host_if_pkg::dma_size_t act);
        if (act !== exp) begin
            fail_run($sformatf("mismatch %s %s: expected %0d actual %0d",
                               test_name, what, exp, act));
        end
    endtask

    task automatic check_word(input string what, input host_if_pkg::word_t exp,
                              input host_if_pkg::word_t act);
        if (act !== exp) begin
            fail_run($sformatf("mismatch %s %s: expected %h actual %h",
                               test_name, what, exp, act));
        end
    endtask

    task automatic check_segment(input string what, input loader_pkg::segment_e exp,
                                 input loader_pkg::segment_e act);
        if (act !== exp) begin
            fail_run($sformatf("mismatch %s %s: expected %s actual %s",
                               test_name, what, exp.name(), act.name()));
        end
    endtask

    task automatic check_count(input string what, input int exp, input int act);
        if (act != exp) begin
            fail_run($sformatf("mismatch %s %s: expected %0d actual %0d",
                               test_name, what, exp, act));
        end
    endtask

    // Host memory word from address, beat index and word index
    function automatic host_if_pkg::word_t beat_word(input host_if_pkg::host_addr_t addr,
                                                     input int idx, input int k);
        host_if_pkg::word_t mix;
        mix = addr[31:0] ^ {addr[47:32], addr[63:48]};
        return mix + 32'(idx) * 32'h0001_0003 + 32'(k) * 32'h9e37_79b9;
    endfunction

    // Word 0 in the lowest bits of the beat
    function automatic host_if_pkg::beat_t make_beat(input host_if_pkg::host_addr_t addr,
                                                     input int idx);
        host_if_pkg::beat_t b;
        for (int k = 0; k < `LDR_WORDS_PER_BEAT; k++) begin
            b[k*`LDR_WORD_W +: `LDR_WORD_W] = beat_word(addr, idx, k);
        end
        return b;
    endfunction

    function automatic host_if_pkg::mmio_addr_t desc_addr(input logic arm,
                                                          input host_if_pkg::dma_size_t size);
        host_if_pkg::mmio_addr_t a;
        a = '0;
        a[`LDR_ARM_BIT] = arm;
        a[`LDR_SIZE_MSB:`LDR_SIZE_LSB] = size[`LDR_SIZE_MSB-`LDR_SIZE_LSB:0];
        return a;
    endfunction

    task automatic expect_segment(input loader_pkg::segment_e seg,
                                  input host_if_pkg::host_addr_t addr,
                                  input host_if_pkg::dma_size_t size);
        exp_addr_q.push_back(addr);
        exp_size_q.push_back(size);
        for (int b = 0; b < int'(size); b++) begin
            for (int k = 0; k < `LDR_WORDS_PER_BEAT; k++) begin
                exp_seg_q.push_back(seg);
                exp_word_q.push_back(beat_word(addr, b, k));
            end
        end
    endtask

    task automatic mmio_write(input host_if_pkg::mmio_addr_t addr,
                              input host_if_pkg::mmio_data_t data);
        mmio_wr_en = 1'b1;
        mmio_wr_addr = addr;
        mmio_wr_data = data;
        @(negedge clk);
        mmio_wr_en = 1'b0;
        mmio_wr_addr = '0;
        mmio_wr_data = '0;
    endtask

    task automatic status_write(input host_if_pkg::mmio_data_t data);
        host_if_pkg::mmio_addr_t a;
        a = desc_addr(1'b1, host_if_pkg::dma_size_t'(2));
        a[`LDR_STATUS_BIT] = 1'b1;
        mmio_write(a, data);
    endtask

    task automatic program_load(input int i);
        expect_segment(loader_pkg::SEG_CP, cp_base[i], host_if_pkg::dma_size_t'(1));
        if (rt_arm[i]) begin
            expect_segment(loader_pkg::SEG_RT, rt_base[i], rt_sz[i]);
        end
        if (const_arm[i]) begin
            expect_segment(loader_pkg::SEG_CONST, const_base[i], const_sz[i]);
        end
        if (extra_status[i]) begin
            status_write(~cp_base[i]);
        end
        mmio_write(desc_addr(1'b1, cp_junk[i]), cp_base[i]);
        mmio_write(desc_addr(rt_arm[i], rt_sz[i]), rt_base[i]);
        if (extra_status[i]) begin
            status_write(~rt_base[i]);
        end
        mmio_write(desc_addr(const_arm[i], const_sz[i]), const_base[i]);
        loads_started++;
        mmio_write('0, '0);
    endtask

    task automatic wait_load_done();
        int n;
        n = 0;
        while (strt_count < loads_started && n < LOAD_TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (strt_count < loads_started) begin
            fail_run($sformatf("%s: cp_strt did not arrive in time", test_name));
        end
    endtask

    // Host DMA presents the head beat and stalls at random
    always @(negedge clk) begin
        stall_rnd = $random(seed);
        if (beat_q.size() == 0) begin
            dma_empty = 1'b1;
            dma_rd_data = '0;
        end else begin
            dma_empty = (stall_rnd % 32'd10) < 32'd3;
            dma_rd_data = beat_q[0];
        end
    end

    always @(posedge clk) begin
        if (rst_n) begin
            if (dma_rd_en && (dma_empty || dma_rd_go || beat_q.size() == 0)) begin
                fail_run($sformatf("%s: dma_rd_en with no beat to pop", test_name));
            end
            if (dma_rd_en) begin
                void'(beat_q.pop_front());
            end
            if (dma_rd_go) begin
                if (exp_addr_q.size() == 0) begin
                    fail_run($sformatf("%s: dma_rd_go with no armed segment", test_name));
                end
                check_addr("dma_rd_addr", exp_addr_q.pop_front(), dma_rd_addr);
                check_size("dma_rd_size", exp_size_q.pop_front(), dma_rd_size);
                for (int b = 0; b < int'(dma_rd_size); b++) begin
                    beat_q.push_back(make_beat(dma_rd_addr, b));
                end
            end
            we_count = int'(we_cp) + int'(we_rt) + int'(we_const);
            if (we_count > 1) begin
                fail_run($sformatf("%s: several write enables high together", test_name));
            end
            if (we_count == 1) begin
                if (exp_word_q.size() == 0) begin
                    fail_run($sformatf("%s: word written with none expected", test_name));
                end
                seen_seg = we_cp ? loader_pkg::SEG_CP :
                           we_rt ? loader_pkg::SEG_RT : loader_pkg::SEG_CONST;
                check_segment("write enable", exp_seg_q.pop_front(), seen_seg);
                check_word("data_32", exp_word_q.pop_front(), data_32);
            end
            if (cp_strt) begin
                if (strt_count >= loads_started) begin
                    fail_run($sformatf("%s: cp_strt without a start write", test_name));
                end
                check_count("words left at cp_strt", 0, exp_word_q.size());
                check_count("segments left at cp_strt", 0, exp_addr_q.size());
                check_count("beats left at cp_strt", 0, beat_q.size());
                strt_count++;
            end
        end
    end

    initial begin
        seed = 97;
        clk = 1'b0;
        rst_n = 1'b0;
        mmio_wr_en = 1'b0;
        mmio_wr_addr = '0;
        mmio_wr_data = '0;
        dma_empty = 1'b1;
        dma_rd_data = '0;
        loads_started = 0;
        strt_count = 0;
        test_name = "reset";
        for (int i = 0; i < NUM_LOADS; i++) begin
            cp_base[i] = {$random(seed), $random(seed)};
            rt_base[i] = {$random(seed), $random(seed)};
            const_base[i] = {$random(seed), $random(seed)};
            cfg_rnd = $random(seed);
            cp_junk[i] = host_if_pkg::dma_size_t'(cfg_rnd[14:2]);
            rt_sz[i] = host_if_pkg::dma_size_t'(cfg_rnd[17:16]);
            const_sz[i] = host_if_pkg::dma_size_t'(cfg_rnd[19:18]);
            rt_arm[i] = cfg_rnd[20];
            const_arm[i] = cfg_rnd[21];
            extra_status[i] = cfg_rnd[22];
        end
        // One full load and one with only CP
        rt_arm[0] = 1'b1;
        const_arm[0] = 1'b1;
        rt_sz[0] = host_if_pkg::dma_size_t'(3);
        const_sz[0] = host_if_pkg::dma_size_t'(2);
        rt_arm[1] = 1'b0;
        const_arm[1] = 1'b0;

        repeat (2) @(negedge clk);
        rst_n = 1'b1;

        test_name = "reset idle";
        if (dma_rd_go || dma_rd_en || we_cp || we_rt || we_const || cp_strt) begin
            fail_run("outputs not low after reset");
        end
        repeat (20) @(negedge clk);

        test_name = "ignored writes";
        mmio_write(desc_addr(1'b0, host_if_pkg::dma_size_t'(3)), 64'h1234_5678_9abc_def0);
        status_write(64'h0fed_cba9_8765_4321);
        status_write(64'h0);
        mmio_write(desc_addr(1'b0, host_if_pkg::dma_size_t'(1)), 64'h0);
        repeat (30) @(negedge clk);

        for (int i = 0; i < NUM_LOADS; i++) begin
            test_name = $sformatf("load %0d", i);
            program_load(i);
            wait_load_done();
            repeat (5) @(negedge clk);
        end

        test_name = "summary";
        repeat (10) @(negedge clk);
        $display("TEST OK");
        $finish;
    end

endmodule

/* param_loader.f */
+incdir+.
host_if_pkg.sv
loader_pkg.sv
mmio_config.sv
read_sequencer.sv
beat_unpacker.sv
dma_read_engine.sv
param_loader.sv
param_loader_properties.sv
tb_param_loader.sv
